// ==== design/cpuPkg.sv ====
// Shared widths, vector types, opcode and funct codes, ALU class codes and ALU operations
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int memAddrWidth = 6;
    localparam int regCount     = 32;
    localparam int memWords     = 64;

    typedef logic [dataWidth-1:0]    dataWord;
    typedef dataWord                 instrWord;  // Full instruction word
    typedef logic [31:0]             pcWord;     // Byte address
    typedef logic [regAddrWidth-1:0] regAddr;
    typedef logic [memAddrWidth-1:0] memAddr;    // Word index into data memory
    typedef logic [5:0]              opCode;
    typedef logic [5:0]              funct;
    typedef logic [1:0]              aluClass;   // Main decoder ALUOp

    localparam pcWord pcStep = 32'd4;

    // ALUOp encoding as the main decoder emits it
    localparam aluClass aluClassSub   = 2'd0;
    localparam aluClass aluClassAdd   = 2'd1;
    localparam aluClass aluClassFunct = 2'd2;

    localparam opCode opRType = 6'd4;
    localparam opCode opAddiu = 6'd12;
    localparam opCode opSubiu = 6'd13;
    localparam opCode opSw    = 6'd16;
    localparam opCode opLw    = 6'd17;

    localparam funct functAdd = 6'd32;
    localparam funct functSub = 6'd34;
    localparam funct functAnd = 6'd36;
    localparam funct functOr  = 6'd37;
    localparam funct functSlt = 6'd42;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp;

endpackage

// ==== design/controlDecoder.sv ====
// Main control decoder from opcode to register, ALU and memory controls
`timescale 1ns/10ps

module controlDecoder (
    input  cpuPkg::opCode   op,
    output logic            regWrite,
    output cpuPkg::aluClass aluClass,
    output logic            regDst,
    output logic            aluSrc,
    output logic            memWrite,
    output logic            memRead,
    output logic            memToReg
);
    import cpuPkg::*;

    always_comb
    begin
        case (op)
            opRType:
            begin
                regWrite = 1'b1;
                aluClass = aluClassFunct; // Operation comes from funct
                regDst   = 1'b1;          // Write into rd
                aluSrc   = 1'b0;
                memWrite = 1'b0;
                memRead  = 1'b0;
                memToReg = 1'b0;
            end
            opAddiu:
            begin
                regWrite = 1'b1;
                aluClass = aluClassAdd;
                regDst   = 1'b0;          // Write into rt
                aluSrc   = 1'b1;          // Sign-extended immediate
                memWrite = 1'b0;
                memRead  = 1'b0;
                memToReg = 1'b0;
            end
            opSubiu:
            begin
                regWrite = 1'b1;
                aluClass = aluClassSub;
                regDst   = 1'b0;
                aluSrc   = 1'b1;
                memWrite = 1'b0;
                memRead  = 1'b0;
                memToReg = 1'b0;
            end
            // Store uses base plus offset and never writes back
            opSw:
            begin
                regWrite = 1'b0;
                aluClass = aluClassAdd;
                regDst   = 1'b0;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                memRead  = 1'b0;
                memToReg = 1'b0;
            end
            opLw:
            begin
                regWrite = 1'b1;
                aluClass = aluClassAdd;
                regDst   = 1'b0;
                aluSrc   = 1'b1;
                memWrite = 1'b0;
                memRead  = 1'b1;
                memToReg = 1'b1;          // Loaded word to rt
            end
            default:                      // Anything else is a no-op
            begin
                regWrite = 1'b0;
                aluClass = aluClassSub;
                regDst   = 1'b0;
                aluSrc   = 1'b0;
                memWrite = 1'b0;
                memRead  = 1'b0;
                memToReg = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/aluControl.sv ====
// ALU control that turns the decoder class and funct into one ALU operation
`timescale 1ns/10ps

module aluControl (
    input  cpuPkg::aluClass aluClass,
    input  cpuPkg::funct    fn,
    output cpuPkg::aluOp    aluSel
);
    import cpuPkg::*;

    aluOp functSel;

    // R-format operation from funct
    always_comb
    begin
        case (fn)
            functAdd: functSel = aluAdd;
            functSub: functSel = aluSub;
            functAnd: functSel = aluAnd;
            functOr:  functSel = aluOr;
            functSlt: functSel = aluSlt;
            default:  functSel = aluAdd; // Unknown funct falls back to add
        endcase
    end

    always_comb
    begin
        case (aluClass)
            aluClassSub:   aluSel = aluSub;
            aluClassAdd:   aluSel = aluAdd;
            aluClassFunct: aluSel = functSel;
            default:       aluSel = aluAdd;
        endcase
    end

endmodule

// ==== design/alu.sv ====
// 32-bit ALU with add, sub, and, or and signed set-less-than
`timescale 1ns/10ps

module alu (
    input  cpuPkg::dataWord operandA,
    input  cpuPkg::dataWord operandB,
    input  cpuPkg::aluOp    aluSel,
    output cpuPkg::dataWord result
);
    import cpuPkg::*;

    dataWord sum;
    dataWord diff;
    logic    lessThan;

    assign sum      = operandA + operandB;
    assign diff     = operandA - operandB;
    assign lessThan = $signed(operandA) < $signed(operandB); // Two's complement compare

    always_comb
    begin
        case (aluSel)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            default: result = sum;
        endcase
    end

endmodule

// ==== design/registerFile.sv ====
// Register file with 32 registers, two async read ports, one sync write port
`timescale 1ns/10ps

module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::regAddr  readAddrA,
    input  cpuPkg::regAddr  readAddrB,
    input  cpuPkg::regAddr  writeAddr,
    input  logic            writeEn,
    input  cpuPkg::dataWord writeValue,
    output cpuPkg::dataWord readDataA,
    output cpuPkg::dataWord readDataB
);
    import cpuPkg::*;

    dataWord regs [regCount];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn && (writeAddr != '0)) // r0 stays zero
        begin
            regs[writeAddr] <= writeValue;
        end
    end

    // Register 0 always reads as zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== design/dataMemory.sv ====
// Data memory of 64 words with sync write, async read and clear on reset
`timescale 1ns/10ps

module dataMemory (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::memAddr  addr,
    input  logic            writeEn,
    input  cpuPkg::dataWord writeValue,
    output cpuPkg::dataWord readValue
);
    import cpuPkg::*;

    dataWord mem [memWords];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < memWords; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            mem[addr] <= writeValue;
        end
    end

    assign readValue = mem[addr]; // Combinational read

endmodule

// ==== design/cpuCore.sv ====
// Single-cycle core top with PC, immediate extension, datapath muxes and block instances
`timescale 1ns/10ps

module cpuCore (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::instrWord instr,
    output cpuPkg::pcWord    pc,
    output logic             regWrite,
    output cpuPkg::regAddr   writeReg,
    output cpuPkg::dataWord  writeData,
    output logic             memWrite,
    output cpuPkg::memAddr   storeAddr,
    output cpuPkg::dataWord  storeData
);
    import cpuPkg::*;

    opCode   instrOp;
    regAddr  rs;
    regAddr  rt;
    regAddr  rd;
    funct    instrFn;
    dataWord immExt;

    logic    regDst;
    logic    aluSrc;
    logic    memRead;
    logic    memToReg;
    aluClass decClass;
    aluOp    aluSel;

    dataWord readDataA;
    dataWord readDataB;
    dataWord operandB;
    dataWord aluResult;
    dataWord memReadValue;
    dataWord loadData;

    // Instruction fields
    assign instrOp = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign instrFn = instr[5:0];
    assign immExt  = {{16{instr[15]}}, instr[15:0]}; // Sign-extend imm16

    // One instruction per cycle, no branches
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc + pcStep;
        end
    end

    controlDecoder uDecoder (
        .op       (instrOp),
        .regWrite (regWrite),
        .aluClass (decClass),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .memWrite (memWrite),
        .memRead  (memRead),
        .memToReg (memToReg)
    );

    aluControl uAluControl (
        .aluClass (decClass),
        .fn       (instrFn),
        .aluSel   (aluSel)
    );

    registerFile uRegs (
        .clk        (clk),
        .rstN       (rstN),
        .readAddrA  (rs),
        .readAddrB  (rt),
        .writeAddr  (writeReg),
        .writeEn    (regWrite),
        .writeValue (writeData),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

    assign operandB = aluSrc ? immExt : readDataB;

    alu uAlu (
        .operandA (readDataA),
        .operandB (operandB),
        .aluSel   (aluSel),
        .result   (aluResult)
    );

    // Word index from the byte address
    assign storeAddr = aluResult[7:2];
    assign storeData = readDataB;     // rt value for sw

    dataMemory uDataMem (
        .clk        (clk),
        .rstN       (rstN),
        .addr       (storeAddr),
        .writeEn    (memWrite),
        .writeValue (storeData),
        .readValue  (memReadValue)
    );

    // Write-back selection
    assign loadData  = memRead ? memReadValue : '0;
    assign writeReg  = regDst ? rd : rt;
    assign writeData = memToReg ? loadData : aluResult;

endmodule

// ==== bench/cpuCore_props.sv ====
// Concurrent assertions on PC stepping and write strobes, bound to cpuCore
`timescale 1ns/10ps

module cpuCoreProps (
    input logic            clk,
    input logic            rstN,
    input cpuPkg::pcWord   pc,
    input logic            regWrite,
    input logic            memWrite,
    input cpuPkg::memAddr  storeAddr
);
    import cpuPkg::*;

    // One word per cycle once out of reset
    pcStepCheck: assert property (@(posedge clk)
        (rstN && $past(rstN)) |-> (pc == $past(pc) + pcStep))
        else $error("pc did not advance by one word");

    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(regWrite && memWrite))
        else $error("regWrite and memWrite are high in the same cycle");

    storeAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> !$isunknown(storeAddr))
        else $error("storeAddr is unknown during a store");

endmodule

bind cpuCore cpuCoreProps props (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .storeAddr (storeAddr)
);

// ==== bench/cpuTb.sv ====
// Testbench for cpuCore that replays instruction patterns from a file and checks each result
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    localparam int resetCycles    = 4;
    localparam int resetTimeout   = 10;
    localparam int patternTimeout = 1000; // Max executed patterns

    logic     clk;
    logic     rstN;
    instrWord instr;
    pcWord    pc;
    logic     regWrite;
    regAddr   writeReg;
    dataWord  writeData;
    logic     memWrite;
    memAddr   storeAddr;
    dataWord  storeData;

    // One pattern line
    instrWord patInstr;
    logic     expRegWrite;
    regAddr   expWriteReg;
    dataWord  expWriteData;
    logic     expMemWrite;
    memAddr   expStoreAddr;
    dataWord  expStoreData;

    int       patternFd;
    string    line;
    int       fields;
    int       waitCycles;
    int       patternCount;
    logic     atEnd;

    cpuCore dut (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .pc        (pc),
        .regWrite  (regWrite),
        .writeReg  (writeReg),
        .writeData (writeData),
        .memWrite  (memWrite),
        .storeAddr (storeAddr),
        .storeData (storeData)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic checkPc(input string name, input pcWord got, input pcWord expected);
        if (got !== expected)
            abortRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic checkWord(input string name, input dataWord got, input dataWord expected);
        if (got !== expected)
            abortRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic checkReg(input string name, input regAddr got, input regAddr expected);
        if (got !== expected)
            abortRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic checkAddr(input string name, input memAddr got, input memAddr expected);
        if (got !== expected)
            abortRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected)
            abortRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    initial
    begin
        rstN  <= 1'b0;
        instr <= '0;      // No-op while in reset
        patternFd = $fopen("bench/cpuPatterns.txt", "r");
        if (patternFd == 0)
            abortRun("Could not open the pattern file bench/cpuPatterns.txt");

        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < resetTimeout)
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (rstN !== 1'b1)
            abortRun("Reset was not released within the expected number of cycles");

        // First cycle after reset still runs the no-op at pc 0
        checkPc("pc", pc, '0);
        checkBit("regWrite", regWrite, 1'b0);
        checkBit("memWrite", memWrite, 1'b0);

        patternCount = 0;
        atEnd        = 1'b0;
        while (!atEnd && patternCount < patternTimeout)
        begin
            if ($fgets(line, patternFd) == 0)
                atEnd = 1'b1;
            else if (line.len() > 1 && line[0] != "#")
            begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h", patInstr, expRegWrite,
                                 expWriteReg, expWriteData, expMemWrite, expStoreAddr,
                                 expStoreData);
                if (fields != 7)
                    abortRun($sformatf("Pattern %0d has %0d fields instead of 7",
                                       patternCount + 1, fields));

                @(posedge clk);
                instr <= patInstr;
                @(negedge clk);
                patternCount++;

                checkPc("pc", pc, pcWord'(patternCount * 4));
                checkBit("regWrite", regWrite, expRegWrite);
                if (expRegWrite)
                begin
                    checkReg("writeReg", writeReg, expWriteReg);
                    checkWord("writeData", writeData, expWriteData);
                end
                checkBit("memWrite", memWrite, expMemWrite);
                if (expMemWrite) // Store port only meaningful on sw
                begin
                    checkAddr("storeAddr", storeAddr, expStoreAddr);
                    checkWord("storeData", storeData, expStoreData);
                end
            end
        end
        $fclose(patternFd);

        if (atEnd && patternCount > 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            if (atEnd)
                abortRun("The pattern file held no instruction lines");
            else
                abortRun("The pattern loop reached its cycle limit before the end of the file");
        end
    end

endmodule

// ==== all.f ====
design/cpuPkg.sv
design/controlDecoder.sv
design/aluControl.sv
design/alu.sv
design/registerFile.sv
design/dataMemory.sv
design/cpuCore.sv
bench/cpuCore_props.sv
bench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the cpuCore testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -f all.f; then
    echo "Verilator build failed"
    exit 1
fi

if [ ! -x ./obj_dir/VcpuTb ]; then
    echo "Simulation executable was not built"
    exit 1
fi

simOutput=$(./obj_dir/VcpuTb)
simStatus=$?
printf '%s\n' "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -q "^Everything OK$"; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

// ==== bench/cpuPatterns.txt ====
# instr regWrite writeReg writeData memWrite storeAddr storeData, all hex
# writeReg/writeData only checked when regWrite is 1, storeAddr/storeData when memWrite is 1
30010005 1 01 00000005 0 00 00000000
3002FFFD 1 02 FFFFFFFD 0 00 00000000
34230002 1 03 00000003 0 00 00000000
3424FFF9 1 04 0000000C 0 00 00000000
10242820 1 05 00000011 0 00 00000000
10243022 1 06 FFFFFFF9 0 00 00000000
10C43824 1 07 00000008 0 00 00000000
10244025 1 08 0000000D 0 00 00000000
1041482A 1 09 00000001 0 00 00000000
1022502A 1 0A 00000000 0 00 00000000
40250007 0 00 00000000 1 03 00000011
40860014 0 00 00000000 1 08 FFFFFFF9
442B0007 1 0B 00000011 0 00 00000000
448C0014 1 0C FFFFFFF9 0 00 00000000
44CDFFFD 1 0D 00000000 0 00 00000000
FC221800 0 00 00000000 0 00 00000000
00000000 0 00 00000000 0 00 00000000
30200009 1 00 0000000E 0 00 00000000
10A60020 1 00 0000000A 0 00 00000000
10007025 1 0E 00000000 0 00 00000000
300F1234 1 0F 00001234 0 00 00000000
40000020 0 00 00000000 1 08 00000000
44100020 1 10 00000000 0 00 00000000
10468822 1 11 00000004 0 00 00000000
10C2902A 1 12 00000001 0 00 00000000
1024983F 1 13 00000011 0 00 00000000
